// ==== hdl/dispatch_pkg.sv ====
/*
 * dispatch_pkg
 * sizes, op classes and queue payload structs shared by the dispatch subsystem.
 */
package dispatch_pkg;

	// datapath and register file sizes.
	localparam int XLEN = 32;
	localparam int ARCH_REGS = 32;

	// four physical copies per architectural register.
	localparam int RP = 4;
	localparam int RB = 2;

	// renamed register is {arch index, copy index}.
	localparam int PREG_W = 5 + RB;

	// queue depths.
	localparam int INSTR_DEPTH = 4;
	localparam int ISSUE_DEPTH = 4;
	localparam int ROB_DEPTH = 8;

	// which issue queue an op goes to; sys ops only reach the reorder queue.
	typedef enum logic [1:0] {
		OP_ALU = 2'd0,
		OP_BRU = 2'd1,
		OP_LSU = 2'd2,
		OP_SYS = 2'd3
	} op_class_t;

	// decoded micro-op as it sits in the instruction queue.
	typedef struct packed {
		op_class_t         op_class;
		logic [3:0]        funct;
		logic [XLEN-1:0]   pc;
		logic [XLEN-1:0]   imm;
		logic [4:0]        rd;
		logic [4:0]        rs1;
		logic [4:0]        rs2;
		logic              writes_rd;
	} decode_op_t;

	// renamed op handed to an issue queue.
	typedef struct packed {
		logic [3:0]        funct;
		logic [XLEN-1:0]   pc;
		logic [XLEN-1:0]   imm;
		logic [PREG_W-1:0] rd;
		logic [PREG_W-1:0] rs1;
		logic [PREG_W-1:0] rs2;
	} issue_t;

	// program-order record kept for commit.
	typedef struct packed {
		op_class_t         op_class;
		logic [XLEN-1:0]   pc;
		logic [PREG_W-1:0] rd;
	} rob_entry_t;

endpackage

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/1ps

/*
 * sync_fifo
 * first-word-fall-through circular queue for any packed payload type.
 */
module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     push,
	input  payload_t din,
	output logic     full,
	input  logic     pop,
	output payload_t dout,
	output logic     empty
);

	payload_t mem [DEPTH];

	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH):0]   count;
	logic [$clog2(DEPTH):0]   count_next;

	// occupancy after this edge.
	always_comb begin
		count_next = count;
		if (push && !pop) begin
			count_next = count + 1'b1;
		end else if (pop && !push) begin
			count_next = count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			full <= 1'b0;
			empty <= 1'b1;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == $clog2(DEPTH)'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == $clog2(DEPTH)'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count_next;
			// flags are registered from the next occupancy.
			full <= (count_next == ($clog2(DEPTH) + 1)'(DEPTH));
			empty <= (count_next == '0);
		end
	end

	// head is read straight out of storage.
	assign dout = mem[rd_ptr];

	a_no_push_full: assert property (@(posedge clk) disable iff (rst) !(push && full));
	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) !(pop && empty));

endmodule

// ==== hdl/rename.sv ====
`timescale 1ns/1ps

/*
 * rename
 * active-copy map and busy bitmap for x0..x31, lowest free copy allocation
 * and release of copies from the commit port.
 */
module rename (
	input  logic                           clk,
	input  logic                           rst,

	input  logic [4:0]                     rs1,
	input  logic [4:0]                     rs2,
	input  logic [4:0]                     rd,
	input  logic                           rd_alloc,

	output logic [dispatch_pkg::PREG_W-1:0] rs1_name,
	output logic [dispatch_pkg::PREG_W-1:0] rs2_name,
	output logic [dispatch_pkg::PREG_W-1:0] rd_name,
	output logic                           rd_run_out,

	input  logic                           commit_valid,
	input  logic [dispatch_pkg::PREG_W-1:0] commit_rd
);

	// current copy per architectural register.
	logic [dispatch_pkg::RB-1:0] act [dispatch_pkg::ARCH_REGS];
	// one bit per physical copy.
	logic [dispatch_pkg::RP-1:0] busy [dispatch_pkg::ARCH_REGS];

	logic [dispatch_pkg::RB-1:0] free_idx;
	logic                        rd_write;
	logic [4:0]                  commit_arch;
	logic [dispatch_pkg::RB-1:0] commit_copy;

	assign commit_arch = commit_rd[dispatch_pkg::PREG_W-1:dispatch_pkg::RB];
	assign commit_copy = commit_rd[dispatch_pkg::RB-1:0];

	// scan downwards so the lowest free copy wins.
	always_comb begin
		free_idx = '0;
		for (int i = dispatch_pkg::RP - 1; i >= 0; i--) begin
			if (!busy[rd][i]) begin
				free_idx = dispatch_pkg::RB'(i);
			end
		end
	end

	// x0 is never renamed, so it can not run out.
	assign rd_run_out = (rd != 5'd0) && (&busy[rd]);
	assign rd_write = rd_alloc && (rd != 5'd0);

	assign rs1_name = (rs1 == 5'd0) ? '0 : {rs1, act[rs1]};
	assign rs2_name = (rs2 == 5'd0) ? '0 : {rs2, act[rs2]};
	assign rd_name = rd_write ? {rd, free_idx} : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < dispatch_pkg::ARCH_REGS; r++) begin
				act[r] <= '0;
				busy[r] <= dispatch_pkg::RP'(1);
			end
		end else begin
			// commit never names the copy being allocated this edge.
			if (commit_valid) begin
				busy[commit_arch][commit_copy] <= 1'b0;
			end
			if (rd_write) begin
				busy[rd][free_idx] <= 1'b1;
				act[rd] <= free_idx;
			end
		end
	end

	a_commit_busy: assert property (@(posedge clk) disable iff (rst)
		commit_valid |-> busy[commit_arch][commit_copy]);

	// dispatch must hold a write back while rd has no free copy.
	a_alloc_free: assert property (@(posedge clk) disable iff (rst)
		rd_alloc |-> !rd_run_out);

endmodule

// ==== hdl/dispatch.sv ====
`timescale 1ns/1ps

/*
 * dispatch
 * takes the instruction queue head, renames it and routes it to one issue
 * queue and the reorder queue in a single cycle.
 */
module dispatch (
	input  logic                            clk,
	input  logic                            rst,

	input  dispatch_pkg::decode_op_t        instr_head,
	input  logic                            instr_empty,
	output logic                            instr_pop,

	output logic                            alu_push,
	output logic                            bru_push,
	output logic                            lsu_push,
	input  logic                            alu_full,
	input  logic                            bru_full,
	input  logic                            lsu_full,
	output dispatch_pkg::issue_t            issue_info,

	output logic                            rob_push,
	input  logic                            rob_full,
	output dispatch_pkg::rob_entry_t        rob_info,

	input  logic                            commit_valid,
	input  logic [dispatch_pkg::PREG_W-1:0] commit_rd
);

	logic [dispatch_pkg::PREG_W-1:0] rs1_name;
	logic [dispatch_pkg::PREG_W-1:0] rs2_name;
	logic [dispatch_pkg::PREG_W-1:0] rd_name;
	logic                            rd_run_out;
	logic                            target_full;
	logic                            dispatch_go;

	// sys ops have no issue queue to wait on.
	always_comb begin
		case (instr_head.op_class)
			dispatch_pkg::OP_ALU: target_full = alu_full;
			dispatch_pkg::OP_BRU: target_full = bru_full;
			dispatch_pkg::OP_LSU: target_full = lsu_full;
			default:              target_full = 1'b0;
		endcase
	end

	assign dispatch_go = !instr_empty && !rob_full && !target_full
		&& !(instr_head.writes_rd && rd_run_out);

	assign instr_pop = dispatch_go;
	assign rob_push = dispatch_go;
	assign alu_push = dispatch_go && (instr_head.op_class == dispatch_pkg::OP_ALU);
	assign bru_push = dispatch_go && (instr_head.op_class == dispatch_pkg::OP_BRU);
	assign lsu_push = dispatch_go && (instr_head.op_class == dispatch_pkg::OP_LSU);

	rename rename_i (
		.clk          (clk),
		.rst          (rst),
		.rs1          (instr_head.rs1),
		.rs2          (instr_head.rs2),
		.rd           (instr_head.rd),
		.rd_alloc     (dispatch_go && instr_head.writes_rd),
		.rs1_name     (rs1_name),
		.rs2_name     (rs2_name),
		.rd_name      (rd_name),
		.rd_run_out   (rd_run_out),
		.commit_valid (commit_valid),
		.commit_rd    (commit_rd)
	);

	// one issue payload shared by all three queues.
	always_comb begin
		issue_info.funct = instr_head.funct;
		issue_info.pc = instr_head.pc;
		issue_info.imm = instr_head.imm;
		issue_info.rd = rd_name;
		issue_info.rs1 = rs1_name;
		issue_info.rs2 = rs2_name;
	end

	always_comb begin
		rob_info.op_class = instr_head.op_class;
		rob_info.pc = instr_head.pc;
		rob_info.rd = rd_name;
	end

	a_one_issue: assert property (@(posedge clk) disable iff (rst)
		$onehot0({alu_push, bru_push, lsu_push}));

	// a stalled head stays put until it dispatches.
	a_head_held: assert property (@(posedge clk) disable iff (rst)
		(!instr_empty && !instr_pop) |=> $stable(instr_head));

endmodule

// ==== hdl/dispatch_top.sv ====
`timescale 1ns/1ps

/*
 * dispatch_top
 * instruction queue, dispatch stage, ALU/BRU/LSU issue queues and reorder queue.
 */
module dispatch_top (
	input  logic                            clk,
	input  logic                            rst,

	input  logic                            in_push,
	input  dispatch_pkg::decode_op_t        in_op,
	output logic                            in_full,

	input  logic                            alu_pop,
	output logic                            alu_empty,
	output dispatch_pkg::issue_t            alu_head,

	input  logic                            bru_pop,
	output logic                            bru_empty,
	output dispatch_pkg::issue_t            bru_head,

	input  logic                            lsu_pop,
	output logic                            lsu_empty,
	output dispatch_pkg::issue_t            lsu_head,

	input  logic                            rob_pop,
	output logic                            rob_empty,
	output dispatch_pkg::rob_entry_t        rob_head,

	input  logic                            commit_valid,
	input  logic [dispatch_pkg::PREG_W-1:0] commit_rd
);

	dispatch_pkg::decode_op_t instr_head;
	logic                     instr_empty;
	logic                     instr_pop;

	logic                     alu_push;
	logic                     alu_full;
	logic                     bru_push;
	logic                     bru_full;
	logic                     lsu_push;
	logic                     lsu_full;
	dispatch_pkg::issue_t     issue_info;

	logic                     rob_push;
	logic                     rob_full;
	dispatch_pkg::rob_entry_t rob_info;

	sync_fifo #(
		.payload_t (dispatch_pkg::decode_op_t),
		.DEPTH     (dispatch_pkg::INSTR_DEPTH)
	) instr_fifo_i (
		.clk(clk), .rst(rst),
		.push(in_push), .din(in_op), .full(in_full),
		.pop(instr_pop), .dout(instr_head), .empty(instr_empty)
	);

	dispatch dispatch_i (
		.clk          (clk),
		.rst          (rst),
		.instr_head   (instr_head),
		.instr_empty  (instr_empty),
		.instr_pop    (instr_pop),
		.alu_push     (alu_push),
		.bru_push     (bru_push),
		.lsu_push     (lsu_push),
		.alu_full     (alu_full),
		.bru_full     (bru_full),
		.lsu_full     (lsu_full),
		.issue_info   (issue_info),
		.rob_push     (rob_push),
		.rob_full     (rob_full),
		.rob_info     (rob_info),
		.commit_valid (commit_valid),
		.commit_rd    (commit_rd)
	);

	// the three issue queues share one payload bus.
	sync_fifo #(
		.payload_t (dispatch_pkg::issue_t),
		.DEPTH     (dispatch_pkg::ISSUE_DEPTH)
	) alu_fifo_i (
		.clk(clk), .rst(rst),
		.push(alu_push), .din(issue_info), .full(alu_full),
		.pop(alu_pop), .dout(alu_head), .empty(alu_empty)
	);

	sync_fifo #(
		.payload_t (dispatch_pkg::issue_t),
		.DEPTH     (dispatch_pkg::ISSUE_DEPTH)
	) bru_fifo_i (
		.clk(clk), .rst(rst),
		.push(bru_push), .din(issue_info), .full(bru_full),
		.pop(bru_pop), .dout(bru_head), .empty(bru_empty)
	);

	sync_fifo #(
		.payload_t (dispatch_pkg::issue_t),
		.DEPTH     (dispatch_pkg::ISSUE_DEPTH)
	) lsu_fifo_i (
		.clk(clk), .rst(rst),
		.push(lsu_push), .din(issue_info), .full(lsu_full),
		.pop(lsu_pop), .dout(lsu_head), .empty(lsu_empty)
	);

	sync_fifo #(
		.payload_t (dispatch_pkg::rob_entry_t),
		.DEPTH     (dispatch_pkg::ROB_DEPTH)
	) rob_fifo_i (
		.clk(clk), .rst(rst),
		.push(rob_push), .din(rob_info), .full(rob_full),
		.pop(rob_pop), .dout(rob_head), .empty(rob_empty)
	);

endmodule

// ==== verification/dispatch_tb.sv ====
`timescale 1ns/1ps

/*
 * dispatch_tb
 * table-driven testbench for dispatch_top with a reference rename model,
 * random pop stalls, an ALU queue held full at the start and a run-out stall.
 */
module dispatch_tb;

	localparam int NROWS = 21;
	localparam int TIMEOUT = 200;

	typedef struct {
		string                   name;
		dispatch_pkg::op_class_t cls;
		logic [3:0]              funct;
		logic [4:0]              rd;
		logic [4:0]              rs1;
		logic [4:0]              rs2;
		logic                    wr;
		logic                    cmt;
	} row_t;

	// name, class, funct, rd, rs1, rs2, writes rd, commit before push.
	row_t rows [NROWS] = '{
		'{"alu_x1",      dispatch_pkg::OP_ALU, 4'h0, 5'd1, 5'd0, 5'd0, 1'b1, 1'b0},
		'{"alu_x2",      dispatch_pkg::OP_ALU, 4'h1, 5'd2, 5'd1, 5'd0, 1'b1, 1'b0},
		'{"bru_beq",     dispatch_pkg::OP_BRU, 4'h0, 5'd0, 5'd1, 5'd2, 1'b0, 1'b0},
		'{"alu_x1_again",dispatch_pkg::OP_ALU, 4'h2, 5'd1, 5'd1, 5'd2, 1'b1, 1'b0},
		'{"lsu_lw",      dispatch_pkg::OP_LSU, 4'h0, 5'd3, 5'd1, 5'd0, 1'b1, 1'b0},
		'{"alu_to_x0",   dispatch_pkg::OP_ALU, 4'h3, 5'd0, 5'd3, 5'd0, 1'b1, 1'b0},
		'{"alu_x4",      dispatch_pkg::OP_ALU, 4'h4, 5'd4, 5'd1, 5'd3, 1'b1, 1'b0},
		'{"alu_no_write",dispatch_pkg::OP_ALU, 4'h5, 5'd5, 5'd4, 5'd0, 1'b0, 1'b0},
		'{"sys_ecall",   dispatch_pkg::OP_SYS, 4'h0, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0},
		'{"lsu_sw",      dispatch_pkg::OP_LSU, 4'h1, 5'd0, 5'd4, 5'd1, 1'b0, 1'b0},
		'{"bru_jal",     dispatch_pkg::OP_BRU, 4'h2, 5'd6, 5'd0, 5'd0, 1'b1, 1'b0},
		'{"alu_x5_a",    dispatch_pkg::OP_ALU, 4'h0, 5'd5, 5'd0, 5'd0, 1'b1, 1'b0},
		'{"alu_x5_b",    dispatch_pkg::OP_ALU, 4'h1, 5'd5, 5'd5, 5'd0, 1'b1, 1'b0},
		'{"alu_x5_c",    dispatch_pkg::OP_ALU, 4'h2, 5'd5, 5'd5, 5'd1, 1'b1, 1'b0},
		'{"alu_x5_d",    dispatch_pkg::OP_ALU, 4'h3, 5'd5, 5'd5, 5'd2, 1'b1, 1'b0},
		'{"bru_x5",      dispatch_pkg::OP_BRU, 4'h1, 5'd0, 5'd5, 5'd1, 1'b0, 1'b0},
		'{"lsu_x7",      dispatch_pkg::OP_LSU, 4'h2, 5'd7, 5'd5, 5'd0, 1'b1, 1'b0},
		'{"sys_mret",    dispatch_pkg::OP_SYS, 4'h1, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0},
		'{"alu_x8",      dispatch_pkg::OP_ALU, 4'h6, 5'd8, 5'd5, 5'd7, 1'b1, 1'b1},
		'{"lsu_x9",      dispatch_pkg::OP_LSU, 4'h3, 5'd9, 5'd8, 5'd0, 1'b1, 1'b0},
		'{"sys_ebreak",  dispatch_pkg::OP_SYS, 4'h2, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0}
	};

	logic                            clk = 1'b0;
	logic                            rst;
	logic                            in_push;
	dispatch_pkg::decode_op_t        in_op;
	logic                            in_full;
	logic                            alu_pop;
	logic                            alu_empty;
	dispatch_pkg::issue_t            alu_head;
	logic                            bru_pop;
	logic                            bru_empty;
	dispatch_pkg::issue_t            bru_head;
	logic                            lsu_pop;
	logic                            lsu_empty;
	dispatch_pkg::issue_t            lsu_head;
	logic                            rob_pop;
	logic                            rob_empty;
	dispatch_pkg::rob_entry_t        rob_head;
	logic                            commit_valid;
	logic [dispatch_pkg::PREG_W-1:0] commit_rd;

	logic [31:0]              row_pc [NROWS];
	logic [31:0]              row_imm [NROWS];
	dispatch_pkg::issue_t     exp_issue [NROWS];
	dispatch_pkg::rob_entry_t exp_rob [NROWS];
	// row indices still expected at each queue, oldest first.
	int                       alu_q [$];
	int                       bru_q [$];
	int                       lsu_q [$];
	int                       rob_q [$];
	// reference rename state.
	logic [1:0]               m_act [32];
	logic [3:0]               m_busy [32];
	int                       pushed = 0;
	int                       model_next = 0;
	int                       rob_seen = 0;
	int                       mismatch_count = 0;
	int                       fail_count = 0;
	logic                     hold_alu = 1'b1;
	logic                     aborted = 1'b0;
	logic [31:0]              stim_state = 32'd55;
	logic [31:0]              pop_state = 32'd55;

	dispatch_top dispatch_top_i (.*);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [6:0] src_name(input logic [4:0] rs);
		if (rs == 5'd0) begin
			return '0;
		end
		return {rs, m_act[rs]};
	endfunction

	function automatic int outstanding();
		return (NROWS - model_next) + alu_q.size() + bru_q.size() + lsu_q.size()
			+ rob_q.size();
	endfunction

	// first ALU row that finds the held ALU queue already full.
	function automatic int first_blocked_alu();
		int seen;
		seen = 0;
		for (int i = 0; i < NROWS; i++) begin
			if (rows[i].cls == dispatch_pkg::OP_ALU) begin
				if (seen == dispatch_pkg::ISSUE_DEPTH) begin
					return i;
				end
				seen++;
			end
		end
		return NROWS;
	endfunction

	task automatic check_issue(input string name, input dispatch_pkg::issue_t want,
		input dispatch_pkg::issue_t got);
		if (got !== want) begin
			mismatch_count++;
			$display("Mismatch %s: expected %h, actual %h", name, want, got);
		end
	endtask

	task automatic check_rob(input string name, input dispatch_pkg::rob_entry_t want,
		input dispatch_pkg::rob_entry_t got);
		if (got !== want) begin
			mismatch_count++;
			$display("Mismatch %s: expected %h, actual %h", name, want, got);
		end
	endtask

	task automatic check_flag(input string name, input logic want, input logic got);
		if (got !== want) begin
			mismatch_count++;
			$display("Mismatch %s: expected %b, actual %b", name, want, got);
		end
	endtask

	task automatic end_run();
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		fail_count++;
		aborted = 1'b1;
		$display("timeout: %s", what);
	endtask

	// renames rows in program order and stops at a head that has no free copy.
	task automatic model_advance();
		dispatch_pkg::issue_t     iss;
		dispatch_pkg::rob_entry_t rob;
		logic [4:0]               rd;
		logic [1:0]               c;
		logic                     found;
		while (model_next < pushed) begin
			rd = rows[model_next].rd;
			if (rows[model_next].wr && rd != 5'd0 && m_busy[rd] == 4'hf) begin
				return;
			end
			iss.rs1 = src_name(rows[model_next].rs1);
			iss.rs2 = src_name(rows[model_next].rs2);
			iss.rd = '0;
			if (rows[model_next].wr && rd != 5'd0) begin
				c = 2'd0;
				found = 1'b0;
				for (int k = 0; k < 4; k++) begin
					if (!found && !m_busy[rd][k]) begin
						c = 2'(k);
						found = 1'b1;
					end
				end
				m_busy[rd][c] = 1'b1;
				m_act[rd] = c;
				iss.rd = {rd, c};
			end
			iss.funct = rows[model_next].funct;
			iss.pc = row_pc[model_next];
			iss.imm = row_imm[model_next];
			rob.op_class = rows[model_next].cls;
			rob.pc = row_pc[model_next];
			rob.rd = iss.rd;
			exp_issue[model_next] = iss;
			exp_rob[model_next] = rob;
			case (rows[model_next].cls)
				dispatch_pkg::OP_ALU: alu_q.push_back(model_next);
				dispatch_pkg::OP_BRU: bru_q.push_back(model_next);
				dispatch_pkg::OP_LSU: lsu_q.push_back(model_next);
				default: ;
			endcase
			rob_q.push_back(model_next);
			model_next++;
		end
	endtask

	task automatic push_row(input int i);
		int n;
		n = 0;
		// while the ALU queue is held, in_full follows the backlog behind it.
		if (hold_alu) begin
			check_flag($sformatf("in_full_before_%s", rows[i].name),
				(i - first_blocked_alu()) >= dispatch_pkg::INSTR_DEPTH, in_full);
		end
		while (in_full && n < TIMEOUT) begin
			// backlog reached, so the ALU queue may drain again.
			hold_alu = 1'b0;
			@(posedge clk);
			#1;
			n++;
		end
		if (in_full) begin
			report_timeout($sformatf("in_full stayed high before pushing %s", rows[i].name));
		end else begin
			stim_state = xorshift(stim_state);
			row_pc[i] = stim_state & 32'hffff_fffc;
			stim_state = xorshift(stim_state);
			row_imm[i] = stim_state;
			in_op.op_class = rows[i].cls;
			in_op.funct = rows[i].funct;
			in_op.pc = row_pc[i];
			in_op.imm = row_imm[i];
			in_op.rd = rows[i].rd;
			in_op.rs1 = rows[i].rs1;
			in_op.rs2 = rows[i].rs2;
			in_op.writes_rd = rows[i].wr;
			in_push = 1'b1;
			@(posedge clk);
			#1;
			in_push = 1'b0;
			pushed++;
			model_advance();
		end
	endtask

	// confirms the run-out stall, then frees the oldest idle copy of its rd.
	task automatic release_stall(input int i);
		logic [4:0] r;
		logic [1:0] c;
		int         n;
		if (model_next >= pushed) begin
			fail_count++;
			$display("%s asks for a commit but no op is stalled on rename", rows[i].name);
			return;
		end
		r = rows[model_next].rd;
		n = 0;
		while (rob_seen < model_next && n < TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (rob_seen < model_next) begin
			report_timeout($sformatf("ops ahead of %s never left the reorder queue",
				rows[model_next].name));
		end else begin
			repeat (8) begin
				@(posedge clk);
				#1;
			end
			check_flag("stall_rob_empty", 1'b1, rob_empty);
			check_flag("stall_in_full", 1'b1, in_full);
			c = 2'd0;
			for (int k = 3; k >= 0; k--) begin
				if (m_busy[r][k] && 2'(k) != m_act[r]) begin
					c = 2'(k);
				end
			end
			commit_valid = 1'b1;
			commit_rd = {r, c};
			@(posedge clk);
			#1;
			commit_valid = 1'b0;
			m_busy[r][c] = 1'b0;
			model_advance();
		end
	endtask

	// pops every queue at random and checks each head it takes.
	always begin : pop_monitor
		logic [31:0] r;
		int          k;
		@(posedge clk);
		#1;
		pop_state = xorshift(pop_state);
		r = pop_state;
		alu_pop = 1'b0;
		bru_pop = 1'b0;
		lsu_pop = 1'b0;
		rob_pop = 1'b0;
		if (!rst && !alu_empty && r[0] && !hold_alu) begin
			if (alu_q.size() == 0) begin
				fail_count++;
				$display("ALU queue delivered an op that was never expected there");
			end else begin
				k = alu_q.pop_front();
				check_issue(rows[k].name, exp_issue[k], alu_head);
			end
			alu_pop = 1'b1;
		end
		if (!rst && !bru_empty && r[1]) begin
			if (bru_q.size() == 0) begin
				fail_count++;
				$display("BRU queue delivered an op that was never expected there");
			end else begin
				k = bru_q.pop_front();
				check_issue(rows[k].name, exp_issue[k], bru_head);
			end
			bru_pop = 1'b1;
		end
		if (!rst && !lsu_empty && r[2]) begin
			if (lsu_q.size() == 0) begin
				fail_count++;
				$display("LSU queue delivered an op that was never expected there");
			end else begin
				k = lsu_q.pop_front();
				check_issue(rows[k].name, exp_issue[k], lsu_head);
			end
			lsu_pop = 1'b1;
		end
		if (!rst && !rob_empty && r[3]) begin
			if (rob_q.size() == 0) begin
				fail_count++;
				$display("reorder queue delivered an op that was never dispatched");
			end else begin
				k = rob_q.pop_front();
				check_rob(rows[k].name, exp_rob[k], rob_head);
			end
			rob_seen++;
			rob_pop = 1'b1;
		end
	end

	initial begin : main
		int n;
		rst = 1'b1;
		in_push = 1'b0;
		in_op = '0;
		alu_pop = 1'b0;
		bru_pop = 1'b0;
		lsu_pop = 1'b0;
		rob_pop = 1'b0;
		commit_valid = 1'b0;
		commit_rd = '0;
		for (int r = 0; r < 32; r++) begin
			m_act[r] = 2'd0;
			m_busy[r] = 4'b0001;
		end
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		check_flag("reset_in_full", 1'b0, in_full);
		check_flag("reset_alu_empty", 1'b1, alu_empty);
		check_flag("reset_bru_empty", 1'b1, bru_empty);
		check_flag("reset_lsu_empty", 1'b1, lsu_empty);
		check_flag("reset_rob_empty", 1'b1, rob_empty);
		for (int i = 0; i < NROWS && !aborted; i++) begin
			if (rows[i].cmt) begin
				release_stall(i);
			end
			if (!aborted) begin
				push_row(i);
			end
		end
		if (!aborted) begin
			n = 0;
			while (outstanding() != 0 && n < TIMEOUT) begin
				@(posedge clk);
				#1;
				n++;
			end
			if (outstanding() != 0) begin
				report_timeout($sformatf("%0d expected results never arrived", outstanding()));
			end else begin
				repeat (2) begin
					@(posedge clk);
					#1;
				end
				check_flag("final_alu_empty", 1'b1, alu_empty);
				check_flag("final_bru_empty", 1'b1, bru_empty);
				check_flag("final_lsu_empty", 1'b1, lsu_empty);
				check_flag("final_rob_empty", 1'b1, rob_empty);
			end
		end
		end_run();
	end

endmodule

// ==== project.f ====
hdl/dispatch_pkg.sv
hdl/sync_fifo.sv
hdl/rename.sv
hdl/dispatch.sv
hdl/dispatch_top.sv
verification/dispatch_tb.sv

// ==== Makefile ====
# Verilator build and run of the dispatch subsystem testbench.

VERILATOR ?= verilator
TOP       ?= dispatch_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
